/* Bender.yml */
package:
  name: ecc_codec

sources:
  - include_dirs:
      - include
    files:
      - hw/ecc_pkg.sv
      - hw/ecc_enc_check.sv
      - hw/ecc_enc_overall.sv
      - hw/ecc_enc_engine.sv
      - hw/ecc_decoder.sv
      - hw/ecc_cw_store.sv
      - hw/ecc_codec_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/ecc_codec_assert.sv
      - verif/ecc_codec_tb.sv

/* ecc_codec.f */
+incdir+include
hw/ecc_pkg.sv
hw/ecc_enc_check.sv
hw/ecc_enc_overall.sv
hw/ecc_enc_engine.sv
hw/ecc_decoder.sv
hw/ecc_cw_store.sv
hw/ecc_codec_top.sv
verif/ecc_codec_assert.sv
verif/ecc_codec_tb.sv

/* hw/ecc_codec_top.sv */
`include "ecc_params.svh"

module ecc_codec_top (
    input  logic                   clk,
    input  logic                   rst,
    input  ecc_pkg::work_mode_e    work_mode,
    input  logic                   enc_req,
    output logic                   enc_ack,
    input  logic [`ECC_ADDR_W-1:0] enc_addr,
    input  ecc_pkg::info_t         enc_info,
    input  logic                   dec_req,
    output logic                   dec_ack,
    input  logic [`ECC_ADDR_W-1:0] dec_addr,
    output ecc_pkg::info_t         dec_info,
    output ecc_pkg::dec_status_e   dec_status,
    input  logic                   raw_req,
    output logic                   raw_ack,
    input  logic                   raw_we,
    input  logic [`ECC_ADDR_W-1:0] raw_addr,
    input  ecc_pkg::codeword_t     raw_wdata,
    output ecc_pkg::codeword_t     raw_rdata
);

    logic                   enc_mem_req;
    logic                   enc_mem_we;
    logic [`ECC_ADDR_W-1:0] enc_mem_addr;
    ecc_pkg::codeword_t     enc_mem_wdata;
    logic                   enc_mem_gnt;
    logic                   dec_mem_req;
    logic                   dec_mem_we;
    logic [`ECC_ADDR_W-1:0] dec_mem_addr;
    logic                   dec_mem_gnt;
    ecc_pkg::codeword_t     mem_rdata;

    ecc_enc_engine ecc_enc_engine_inst (
        .clk       (clk),
        .rst       (rst),
        .enc_req   (enc_req),
        .enc_addr  (enc_addr),
        .enc_info  (enc_info),
        .work_mode (work_mode),
        .enc_ack   (enc_ack),
        .mem_req   (enc_mem_req),
        .mem_we    (enc_mem_we),
        .mem_addr  (enc_mem_addr),
        .mem_wdata (enc_mem_wdata),
        .mem_gnt   (enc_mem_gnt)
    );

    ecc_decoder ecc_decoder_inst (
        .clk        (clk),
        .rst        (rst),
        .dec_req    (dec_req),
        .dec_addr   (dec_addr),
        .work_mode  (work_mode),
        .dec_ack    (dec_ack),
        .dec_info   (dec_info),
        .dec_status (dec_status),
        .mem_req    (dec_mem_req),
        .mem_we     (dec_mem_we),
        .mem_addr   (dec_mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_gnt    (dec_mem_gnt)
    );

    ecc_cw_store ecc_cw_store_inst (
        .clk           (clk),
        .rst           (rst),
        .enc_mem_req   (enc_mem_req),
        .enc_mem_we    (enc_mem_we),
        .enc_mem_addr  (enc_mem_addr),
        .enc_mem_wdata (enc_mem_wdata),
        .enc_mem_gnt   (enc_mem_gnt),
        .dec_mem_req   (dec_mem_req),
        .dec_mem_we    (dec_mem_we),
        .dec_mem_addr  (dec_mem_addr),
        .dec_mem_wdata ('0),  // decoder never writes
        .dec_mem_gnt   (dec_mem_gnt),
        .raw_req       (raw_req),
        .raw_we        (raw_we),
        .raw_addr      (raw_addr),
        .raw_wdata     (raw_wdata),
        .raw_ack       (raw_ack),
        .raw_rdata     (raw_rdata),
        .mem_rdata     (mem_rdata)
    );

endmodule

/* hw/ecc_cw_store.sv */
`include "ecc_params.svh"

module ecc_cw_store (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enc_mem_req,
    input  logic                   enc_mem_we,
    input  logic [`ECC_ADDR_W-1:0] enc_mem_addr,
    input  ecc_pkg::codeword_t     enc_mem_wdata,
    output logic                   enc_mem_gnt,
    input  logic                   dec_mem_req,
    input  logic                   dec_mem_we,
    input  logic [`ECC_ADDR_W-1:0] dec_mem_addr,
    input  ecc_pkg::codeword_t     dec_mem_wdata,
    output logic                   dec_mem_gnt,
    input  logic                   raw_req,
    input  logic                   raw_we,
    input  logic [`ECC_ADDR_W-1:0] raw_addr,
    input  ecc_pkg::codeword_t     raw_wdata,
    output logic                   raw_ack,
    output ecc_pkg::codeword_t     raw_rdata,
    output ecc_pkg::codeword_t     mem_rdata
);

    localparam int n_peers = 3;  // enc, dec, raw by index

    logic                   raw_mem_req;
    logic                   raw_mem_gnt;
    logic                   raw_rd_pend;  // raw read waiting for its data
    logic [n_peers-1:0]     req;
    logic [n_peers-1:0]     gnt;
    logic [1:0]             ptr;          // peer with top priority
    logic [1:0]             idx;
    logic                   gnt_we;
    logic [`ECC_ADDR_W-1:0] gnt_addr;
    ecc_pkg::codeword_t     gnt_wdata;
    ecc_pkg::codeword_t     mem [`ECC_MEM_DEPTH];

    assign raw_mem_req = raw_req && !raw_ack && !raw_rd_pend;
    assign req         = {raw_mem_req, dec_mem_req, enc_mem_req};

    // first requester at or after ptr wins
    always_comb begin
        gnt = '0;
        idx = ptr;
        for (int k = 0; k < n_peers; k++) begin
            if (gnt == '0 && req[idx]) begin
                gnt[idx] = 1'b1;
            end
            idx = (idx == 2'(n_peers - 1)) ? 2'd0 : idx + 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ptr <= '0;
        end else if (gnt[0]) begin
            ptr <= 2'd1;
        end else if (gnt[1]) begin
            ptr <= 2'd2;
        end else if (gnt[2]) begin
            ptr <= 2'd0;
        end
    end

    always_comb begin
        gnt_we    = 1'b0;
        gnt_addr  = enc_mem_addr;
        gnt_wdata = enc_mem_wdata;
        if (gnt[1]) begin
            gnt_we    = dec_mem_we;
            gnt_addr  = dec_mem_addr;
            gnt_wdata = dec_mem_wdata;
        end else if (gnt[2]) begin
            gnt_we    = raw_we;
            gnt_addr  = raw_addr;
            gnt_wdata = raw_wdata;
        end else if (gnt[0]) begin
            gnt_we = enc_mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (|gnt && gnt_we) begin
            mem[gnt_addr] <= gnt_wdata;
        end
    end

    // one shared read register, only the granted reader looks at it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_rdata <= '0;
        end else if (|gnt && !gnt_we) begin
            mem_rdata <= mem[gnt_addr];
        end
    end

    // raw port four-phase handshake
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            raw_ack     <= 1'b0;
            raw_rd_pend <= 1'b0;
            raw_rdata   <= '0;
        end else begin
            raw_rd_pend <= raw_mem_gnt && !raw_we;
            if (raw_mem_gnt && raw_we) begin
                raw_ack <= 1'b1;
            end else if (raw_rd_pend) begin
                raw_ack   <= 1'b1;
                raw_rdata <= mem_rdata;
            end else if (!raw_req) begin
                raw_ack <= 1'b0;
            end
        end
    end

    assign enc_mem_gnt = gnt[0];
    assign dec_mem_gnt = gnt[1];
    assign raw_mem_gnt = gnt[2];

endmodule

/* hw/ecc_decoder.sv */
`include "ecc_params.svh"

module ecc_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dec_req,
    input  logic [`ECC_ADDR_W-1:0] dec_addr,
    input  ecc_pkg::work_mode_e    work_mode,
    output logic                   dec_ack,
    output ecc_pkg::info_t         dec_info,
    output ecc_pkg::dec_status_e   dec_status,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [`ECC_ADDR_W-1:0] mem_addr,
    input  ecc_pkg::codeword_t     mem_rdata,
    input  logic                   mem_gnt
);

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_calc,  // read data valid this cycle
        s_ack
    } state_e;

    state_e                 state;
    logic [`ECC_CHK_W-1:0]  syndrome;
    logic [`ECC_CHK_W-1:0]  column;
    logic                   parity_err;
    ecc_pkg::codeword_t     flip;
    ecc_pkg::codeword_t     fixed_cw;
    ecc_pkg::codeword_t     info_mask;
    ecc_pkg::info_t         info_next;
    ecc_pkg::dec_status_e   status_next;

    assign parity_err = ^mem_rdata;  // stored words have even parity

    always_comb begin
        syndrome = '0;
        column   = '0;
        flip     = '0;
        if (work_mode != ecc_pkg::mode_rsvd) begin
            for (int j = 0; j < `ECC_CHK_W; j++) begin
                syndrome[j] = ^(mem_rdata & ecc_pkg::h_rows[work_mode][j]);
            end
            // find the H column that matches the syndrome
            for (int i = 0; i < `ECC_CW_W; i++) begin
                for (int j = 0; j < `ECC_CHK_W; j++) begin
                    column[j] = ecc_pkg::h_rows[work_mode][j][i];
                end
                if (syndrome != '0 && column == syndrome) begin
                    flip[i] = 1'b1;
                end
            end
        end
    end

    assign fixed_cw  = mem_rdata ^ flip;
    assign info_mask = (ecc_pkg::codeword_t'(1) << ecc_pkg::info_width(work_mode)) - 1'b1;

    always_comb begin
        info_next = ecc_pkg::info_t'((fixed_cw >> ecc_pkg::parity_width(work_mode))
                                     & info_mask);
        if (work_mode == ecc_pkg::mode_rsvd) begin
            status_next = ecc_pkg::st_bad_mode;
        end else if (parity_err) begin
            status_next = ecc_pkg::st_corrected;  // covers a bad overall bit too
        end else if (syndrome != '0) begin
            status_next = ecc_pkg::st_double;
            info_next   = '0;
        end else begin
            status_next = ecc_pkg::st_clean;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:  if (dec_req) state <= s_read;
                s_read:  if (mem_gnt) state <= s_calc;
                s_calc:  state <= s_ack;
                s_ack:   if (!dec_req) state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    // result held for the whole ack phase
    always_ff @(posedge clk) begin
        if (state == s_calc) begin
            dec_info   <= info_next;
            dec_status <= status_next;
        end
    end

    assign dec_ack  = (state == s_ack);
    assign mem_req  = (state == s_read);
    assign mem_we   = 1'b0;  // read only peer
    assign mem_addr = dec_addr;

endmodule

/* hw/ecc_enc_check.sv */
`include "ecc_params.svh"

module ecc_enc_check (
    input  logic                clk,
    input  logic                rst,
    input  ecc_pkg::work_mode_e work_mode,
    input  ecc_pkg::info_t      info,
    output ecc_pkg::codeword_t  cw_out
);

    ecc_pkg::codeword_t info_mask;
    ecc_pkg::codeword_t placed;
    ecc_pkg::codeword_t cw_next;
    int                 n_chk;

    // only the low info bits of the mode survive, zero for the reserved mode
    assign info_mask = (ecc_pkg::codeword_t'(1) << ecc_pkg::info_width(work_mode)) - 1'b1;

    // info field sits right above the parity slots
    assign placed = (ecc_pkg::codeword_t'(info) & info_mask)
                    << ecc_pkg::parity_width(work_mode);

    assign n_chk = ecc_pkg::parity_width(work_mode) - 1;

    always_comb begin
        cw_next = placed;  // check slots and overall slot start at zero
        if (work_mode != ecc_pkg::mode_rsvd) begin
            for (int j = 0; j < `ECC_CHK_W; j++) begin
                // rows past the last check bit would hit the overall slot or info
                if (j < n_chk) begin
                    cw_next[j] = ^(placed & ecc_pkg::h_rows[work_mode][j]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cw_out <= '0;
        end else begin
            cw_out <= cw_next;
        end
    end

endmodule

/* hw/ecc_enc_engine.sv */
`include "ecc_params.svh"

module ecc_enc_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enc_req,
    input  logic [`ECC_ADDR_W-1:0] enc_addr,
    input  ecc_pkg::info_t         enc_info,
    input  ecc_pkg::work_mode_e    work_mode,
    output logic                   enc_ack,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [`ECC_ADDR_W-1:0] mem_addr,
    output ecc_pkg::codeword_t     mem_wdata,
    input  logic                   mem_gnt
);

    typedef enum logic [1:0] {
        s_idle,
        s_fill,   // stage 1 holds the check bits
        s_write,  // stage 2 holds the full codeword
        s_ack
    } state_e;

    state_e             state;
    ecc_pkg::codeword_t check_cw;
    ecc_pkg::codeword_t full_cw;

    ecc_enc_check check_inst (
        .clk       (clk),
        .rst       (rst),
        .work_mode (work_mode),
        .info      (enc_info),
        .cw_out    (check_cw)
    );

    ecc_enc_overall overall_inst (
        .clk       (clk),
        .rst       (rst),
        .work_mode (work_mode),
        .cw_in     (check_cw),
        .cw_out    (full_cw)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:  if (enc_req) state <= s_fill;
                s_fill:  state <= s_write;
                s_write: if (mem_gnt) state <= s_ack;  // hold request until granted
                s_ack:   if (!enc_req) state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    assign enc_ack   = (state == s_ack);
    assign mem_req   = (state == s_write);
    assign mem_we    = mem_req;
    assign mem_addr  = enc_addr;  // host keeps it stable
    assign mem_wdata = full_cw;

endmodule

/* hw/ecc_enc_overall.sv */
module ecc_enc_overall (
    input  logic                clk,
    input  logic                rst,
    input  ecc_pkg::work_mode_e work_mode,
    input  ecc_pkg::codeword_t  cw_in,
    output ecc_pkg::codeword_t  cw_out
);

    localparam int cw_w  = $bits(ecc_pkg::codeword_t);
    localparam int pw_1  = ecc_pkg::parity_width(ecc_pkg::mode_1);
    localparam int pw_2  = ecc_pkg::parity_width(ecc_pkg::mode_2);
    localparam int pw_3  = ecc_pkg::parity_width(ecc_pkg::mode_3);
    localparam int top_1 = pw_1 + ecc_pkg::info_width(ecc_pkg::mode_1);  // first pad bit
    localparam int top_2 = pw_2 + ecc_pkg::info_width(ecc_pkg::mode_2);

    logic               overall;
    ecc_pkg::codeword_t cw_next;

    // overall slot of cw_in is still zero, so this is even parity over the word
    assign overall = ^cw_in;

    always_comb begin
        case (work_mode)
            ecc_pkg::mode_1: cw_next = {{(cw_w - top_1){1'b0}},
                                        cw_in[top_1-1:pw_1],
                                        overall,
                                        cw_in[pw_1-2:0]};
            ecc_pkg::mode_2: cw_next = {{(cw_w - top_2){1'b0}},
                                        cw_in[top_2-1:pw_2],
                                        overall,
                                        cw_in[pw_2-2:0]};
            ecc_pkg::mode_3: cw_next = {cw_in[cw_w-1:pw_3],  // no padding left
                                        overall,
                                        cw_in[pw_3-2:0]};
            default:         cw_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cw_out <= '0;
        end else begin
            cw_out <= cw_next;
        end
    end

endmodule

/* hw/ecc_pkg.sv */
`include "ecc_params.svh"

package ecc_pkg;

    typedef enum logic [1:0] {
        mode_1    = 2'd0,  // 4 info, 4 parity
        mode_2    = 2'd1,  // 11 info, 5 parity
        mode_3    = 2'd2,  // 26 info, 6 parity
        mode_rsvd = 2'd3
    } work_mode_e;

    typedef enum logic [1:0] {
        st_clean     = 2'd0,
        st_corrected = 2'd1,
        st_double    = 2'd2,
        st_bad_mode  = 2'd3
    } dec_status_e;

    typedef logic [`ECC_CW_W-1:0]   codeword_t;
    typedef logic [`ECC_INFO_W-1:0] info_t;

    function automatic int info_width(work_mode_e mode);
        case (mode)
            mode_1:  return 4;
            mode_2:  return 11;
            mode_3:  return 26;
            default: return 0;
        endcase
    endfunction

    // check bits plus the overall bit
    function automatic int parity_width(work_mode_e mode);
        case (mode)
            mode_1:  return 4;
            mode_2:  return 5;
            mode_3:  return 6;
            default: return 0;
        endcase
    endfunction

    // zero padded H rows, row j covers check bit j and the info bits it protects
    // overall parity row is all ones and is not stored
    localparam codeword_t h_rows [`ECC_MODES][`ECC_CHK_W] = '{
        '{32'h0000_00b1, 32'h0000_00d2, 32'h0000_00e4, 32'h0000_0000, 32'h0000_0000},
        '{32'h0000_ab61, 32'h0000_cda2, 32'h0000_f1c4, 32'h0000_fe08, 32'h0000_0000},
        '{32'haaab_56c1, 32'hcccd_9b42, 32'hf0f1_e384, 32'hff01_fc08, 32'hfffe_0010}
    };

endpackage

/* include/ecc_params.svh */
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// codeword geometry
`define ECC_CW_W      32
`define ECC_INFO_W    26

// hamming check bits of the widest mode, overall bit not counted
`define ECC_CHK_W     5

// mode_1 .. mode_3, reserved mode has no row set
`define ECC_MODES     3

// codeword store
`define ECC_MEM_DEPTH 16
`define ECC_ADDR_W    4

`endif

/* verif/ecc_codec_assert.sv */
module ecc_codec_assert #(
    parameter int n_mem  = 3,
    parameter int n_host = 3
) (
    input logic              clk,
    input logic              rst,
    input logic [n_mem-1:0]  mem_req,
    input logic [n_mem-1:0]  mem_gnt,
    input logic [n_host-1:0] host_req,
    input logic [n_host-1:0] host_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // summed by the testbench at the end

    grant_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(mem_gnt))
        else begin
            $error("more than one memory grant in one cycle");
            fail_count++;
        end

    grant_needs_req: assert property (@(posedge clk) disable iff (!rst)
        (mem_gnt & ~mem_req) == '0)
        else begin
            $error("memory grant given without a request");
            fail_count++;
        end

    // one lane per host port
    for (genvar i = 0; i < n_host; i++) begin : g_handshake
        ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
            $rose(host_ack[i]) |-> host_req[i])
            else begin
                $error("ack rose on port %0d without a request", i);
                fail_count++;
            end

        ack_after_req_drop: assert property (@(posedge clk) disable iff (!rst)
            $fell(host_ack[i]) |-> !$past(host_req[i]))
            else begin
                $error("ack dropped on port %0d while its request was high", i);
                fail_count++;
            end
    end

endmodule

// arbiter over all three peers, raw handshake lives in the store
bind ecc_cw_store ecc_codec_assert #(.n_mem(3), .n_host(1)) store_assert_inst (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (req),
    .mem_gnt  (gnt),
    .host_req (raw_req),
    .host_ack (raw_ack)
);

// engine side of the store port and the encode and decode handshakes
bind ecc_codec_top ecc_codec_assert #(.n_mem(2), .n_host(2)) top_assert_inst (
    .clk      (clk),
    .rst      (rst),
    .mem_req  ({dec_mem_req, enc_mem_req}),
    .mem_gnt  ({dec_mem_gnt, enc_mem_gnt}),
    .host_req ({dec_req, enc_req}),
    .host_ack ({dec_ack, enc_ack})
);

/* verif/ecc_codec_cases.txt */
// op mode addr data exp_cw exp_info exp_status
// op 0 encode+readback, 1 raw write, 2 decode, 3 raw read, 4 encode with decode and read at addr+8
0 0 0 0000000b 000000b1 00000000 0
0 0 1 00000006 00000063 00000000 0
0 1 2 00000001 00000033 00000000 0
0 1 3 000007ff 0000ffff 00000000 0
0 2 4 00000001 00000063 00000000 0
0 2 5 03ffffff ffffffff 00000000 0
0 3 6 0000abcd 00000000 00000000 0
2 0 0 00000000 00000000 0000000b 0
2 1 3 00000000 00000000 000007ff 0
2 2 5 00000000 00000000 03ffffff 0
2 3 6 00000000 00000000 00000000 3
1 0 0 000000f1 00000000 00000000 0
2 0 0 00000000 00000000 0000000b 1
1 0 1 0000006b 00000000 00000000 0
2 0 1 00000000 00000000 00000006 1
1 1 2 00000032 00000000 00000000 0
2 1 2 00000000 00000000 00000001 1
1 2 4 00080063 00000000 00000000 0
2 2 4 00000000 00000000 00000001 1
1 2 5 7fffffef 00000000 00000000 0
2 2 5 00000000 00000000 00000000 2
1 0 0 000000b7 00000000 00000000 0
2 0 0 00000000 00000000 00000000 2
0 1 9 00000001 00000033 00000000 0
0 1 a 000007ff 0000ffff 00000000 0
4 1 1 000007ff 00000033 00000001 0
3 1 1 00000000 0000ffff 00000000 0
4 1 2 00000001 0000ffff 000007ff 0
3 1 2 00000000 00000033 00000000 0

/* verif/ecc_codec_tb.sv */
`include "ecc_params.svh"

module ecc_codec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_cases      = 29;
    localparam int words_per_case = 7;
    localparam int cycle_limit    = num_cases * 40;

    logic                   clk;
    logic                   rst;
    ecc_pkg::work_mode_e    work_mode;
    logic                   enc_req;
    logic                   enc_ack;
    logic [`ECC_ADDR_W-1:0] enc_addr;
    ecc_pkg::info_t         enc_info;
    logic                   dec_req;
    logic                   dec_ack;
    logic [`ECC_ADDR_W-1:0] dec_addr;
    ecc_pkg::info_t         dec_info;
    ecc_pkg::dec_status_e   dec_status;
    logic                   raw_req;
    logic                   raw_ack;
    logic                   raw_we;
    logic [`ECC_ADDR_W-1:0] raw_addr;
    ecc_pkg::codeword_t     raw_wdata;
    ecc_pkg::codeword_t     raw_rdata;

    logic [31:0] case_mem [num_cases*words_per_case];
    logic [31:0] rng_state;
    int          errors;
    int          passed;
    int          failed;
    int          cycles;
    int          assert_fails;

    ecc_codec_top ecc_codec_top_inst (
        .clk        (clk),
        .rst        (rst),
        .work_mode  (work_mode),
        .enc_req    (enc_req),
        .enc_ack    (enc_ack),
        .enc_addr   (enc_addr),
        .enc_info   (enc_info),
        .dec_req    (dec_req),
        .dec_ack    (dec_ack),
        .dec_addr   (dec_addr),
        .dec_info   (dec_info),
        .dec_status (dec_status),
        .raw_req    (raw_req),
        .raw_ack    (raw_ack),
        .raw_we     (raw_we),
        .raw_addr   (raw_addr),
        .raw_wdata  (raw_wdata),
        .raw_rdata  (raw_rdata)
    );

    always #2 clk = ~clk;

    // watchdog over the whole run
    always @(posedge clk) begin
        if (rst) begin
            cycles <= cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("timeout: a handshake did not complete within %0d cycles",
                         cycle_limit);
                $display("Some tests failed");
                $finish;
            end
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic string op_name(logic [31:0] op);
        case (op)
            0:       return "encode";
            1:       return "raw_write";
            2:       return "decode";
            3:       return "raw_read";
            4:       return "contention";
            default: return "unknown";
        endcase
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic encode_word(input logic [`ECC_ADDR_W-1:0] addr, input ecc_pkg::info_t info);
        @(posedge clk);
        enc_addr <= addr;
        enc_info <= info;
        enc_req  <= 1'b1;
        @(negedge clk);
        while (!enc_ack) @(negedge clk);
        @(posedge clk);
        enc_req <= 1'b0;
        @(negedge clk);
        while (enc_ack) @(negedge clk);
    endtask

    task automatic decode_word(input logic [`ECC_ADDR_W-1:0] addr,
                               output ecc_pkg::info_t info,
                               output ecc_pkg::dec_status_e status);
        @(posedge clk);
        dec_addr <= addr;
        dec_req  <= 1'b1;
        @(negedge clk);
        while (!dec_ack) @(negedge clk);
        info   = dec_info;  // valid while ack is high
        status = dec_status;
        @(posedge clk);
        dec_req <= 1'b0;
        @(negedge clk);
        while (dec_ack) @(negedge clk);
    endtask

    task automatic raw_access(input logic we, input logic [`ECC_ADDR_W-1:0] addr,
                              input ecc_pkg::codeword_t wdata,
                              output ecc_pkg::codeword_t rdata);
        @(posedge clk);
        raw_we    <= we;
        raw_addr  <= addr;
        raw_wdata <= wdata;
        raw_req   <= 1'b1;
        @(negedge clk);
        while (!raw_ack) @(negedge clk);
        rdata = raw_rdata;
        @(posedge clk);
        raw_req <= 1'b0;
        @(negedge clk);
        while (raw_ack) @(negedge clk);
    endtask

    task automatic check_cw(input string name, input ecc_pkg::codeword_t exp,
                            input ecc_pkg::codeword_t act);
        if (act !== exp) begin
            $display("Mismatch %s: codeword expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_info(input string name, input ecc_pkg::info_t exp,
                              input ecc_pkg::info_t act);
        if (act !== exp) begin
            $display("Mismatch %s: info expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input ecc_pkg::dec_status_e exp,
                                input ecc_pkg::dec_status_e act);
        if (act !== exp) begin
            $display("Mismatch %s: status expected %s, actual %b", name, exp.name(), act);
            errors++;
        end
    endtask

    task automatic run_case(input int n);
        logic [31:0]            op;
        logic [`ECC_ADDR_W-1:0] addr;
        logic [`ECC_ADDR_W-1:0] side_addr;
        logic [31:0]            data;
        ecc_pkg::codeword_t     exp_cw;
        ecc_pkg::info_t         exp_info;
        ecc_pkg::dec_status_e   exp_status;
        ecc_pkg::codeword_t     rd_cw;
        ecc_pkg::info_t         rd_info;
        ecc_pkg::dec_status_e   rd_status;
        int                     gap_enc;
        int                     gap_dec;
        int                     gap_raw;
        int                     errs_before;
        string                  name;

        op         = case_mem[n*words_per_case];
        addr       = case_mem[n*words_per_case+2][`ECC_ADDR_W-1:0];
        data       = case_mem[n*words_per_case+3];
        exp_cw     = case_mem[n*words_per_case+4];
        exp_info   = case_mem[n*words_per_case+5][`ECC_INFO_W-1:0];
        exp_status = ecc_pkg::dec_status_e'(case_mem[n*words_per_case+6][1:0]);
        side_addr  = addr + `ECC_ADDR_W'(8);  // contention peers look at the upper half
        errs_before = errors;
        name = $sformatf("case%0d_%s", n, op_name(op));

        @(posedge clk);
        work_mode <= ecc_pkg::work_mode_e'(case_mem[n*words_per_case+1][1:0]);
        idle_cycles(int'(next_rand() % 4));

        case (op)
            0: begin
                encode_word(addr, data[`ECC_INFO_W-1:0]);
                raw_access(1'b0, addr, '0, rd_cw);
                check_cw(name, exp_cw, rd_cw);
            end
            1: raw_access(1'b1, addr, data, rd_cw);  // fault injection
            2: begin
                decode_word(addr, rd_info, rd_status);
                check_info(name, exp_info, rd_info);
                check_status(name, exp_status, rd_status);
            end
            3: begin
                raw_access(1'b0, addr, '0, rd_cw);
                check_cw(name, exp_cw, rd_cw);
            end
            4: begin
                gap_enc = int'(next_rand() % 6);
                gap_dec = int'(next_rand() % 6);
                gap_raw = int'(next_rand() % 6);
                fork
                    begin
                        idle_cycles(gap_enc);
                        encode_word(addr, data[`ECC_INFO_W-1:0]);
                    end
                    begin
                        idle_cycles(gap_dec);
                        decode_word(side_addr, rd_info, rd_status);
                        check_info(name, exp_info, rd_info);
                        check_status(name, exp_status, rd_status);
                    end
                    begin
                        idle_cycles(gap_raw);
                        raw_access(1'b0, side_addr, '0, rd_cw);
                        check_cw(name, exp_cw, rd_cw);
                    end
                join
            end
            default: begin
                $display("%s: unknown operation code %0h in the case file", name, op);
                errors++;
            end
        endcase

        if (errors == errs_before) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: FAIL", name);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        work_mode = ecc_pkg::mode_1;
        enc_req   = 1'b0;
        enc_addr  = '0;
        enc_info  = '0;
        dec_req   = 1'b0;
        dec_addr  = '0;
        raw_req   = 1'b0;
        raw_we    = 1'b0;
        raw_addr  = '0;
        raw_wdata = '0;
        rng_state = 32'hfd3f_fea8;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        cycles    = 0;
        $readmemh("verif/ecc_codec_cases.txt", case_mem);

        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        for (int n = 0; n < num_cases; n++) begin
            run_case(n);
        end

        // bound checkers in the top level and in the store
        assert_fails = ecc_codec_top_inst.top_assert_inst.fail_count
                       + ecc_codec_top_inst.ecc_cw_store_inst.store_assert_inst.fail_count;

        $display("cases run %0d, passed %0d, failed %0d, assertion failures %0d",
                 num_cases, passed, failed, assert_fails);
        if (failed == 0 && assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
